/* src/nrx_params.svh */
`ifndef NRX_PARAMS_SVH
`define NRX_PARAMS_SVH

// ------------------------------
// CPU bus
// ------------------------------
`define NRX_ADDR_W      16      // Z80 address bus
`define NRX_DATA_W      8       // Z80 data bus
`define NRX_RAM_AW      11      // 2 KB work RAM

// CLK cycles per CPU enable
`define NRX_CPU_DIV     8

// ------------------------------
// Raster
// ------------------------------
`define NRX_PIX_DIV     4       // CLK cycles per pixel
`define NRX_H_TOTAL     384     // Pixels per line incl. blanking
`define NRX_H_VISIBLE   288
`define NRX_V_TOTAL     264     // Lines per frame
`define NRX_V_VISIBLE   224

// Sync pulses sit inside the blanking intervals
`define NRX_HSYNC_START 304
`define NRX_VSYNC_START 240
`define NRX_SYNC_LEN    16      // Pixels for hsync, lines for vsync

// Vblank interrupt window
`define NRX_VBLK_LINE   224     // Line that raises the request
`define NRX_VBLK_HMAX   8       // Last pixel of the window

`endif

/* src/nrx_bus_pkg.sv */
`default_nettype none

`include "nrx_params.svh"

package nrx_bus_pkg;

	// ------------------------------
	// CPU side types
	// ------------------------------

	// Full Z80 address word
	typedef logic [`NRX_ADDR_W-1:0] addr_t;

	// One data byte
	typedef logic [`NRX_DATA_W-1:0] byte_t;

	// Control latch slots at A180-A187
	// Index is addr[2:0]; 2, 3, 6, 7 are unused on this board
	typedef enum logic [2:0] {
		bang       = 3'd0,  // Sound trigger
		irq_enable = 3'd1,  // Vblank interrupt enable
		lamp0      = 3'd4,  // Start lamp 1
		lamp1      = 3'd5   // Start lamp 2
	} latch_t;

endpackage

`default_nettype wire

/* src/nrx_video_pkg.sv */
`default_nettype none

package nrx_video_pkg;

	// ------------------------------
	// Raster position types
	// ------------------------------

	// Pixel within a line, 0..383
	typedef logic [8:0] hpos_t;

	// Line within a frame, 0..263
	typedef logic [8:0] vpos_t;

endpackage

`default_nettype wire

/* src/nrx_spram.sv */
`default_nettype none

`include "nrx_params.svh"

module nrx_spram #(
	parameter int ram_aw = `NRX_RAM_AW  // Depth is 2**ram_aw bytes
) (
	input  wire                 CLK,
	input  wire  [ram_aw-1:0]   addr,
	input  wire                 we,
	input  wire  nrx_bus_pkg::byte_t d,
	output nrx_bus_pkg::byte_t  q
);

	nrx_bus_pkg::byte_t mem [2**ram_aw];

	// Registered read, write data passes straight to q
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= d;
			q <= d;     // Write-first
		end else begin
			q <= mem[addr];
		end
	end

endmodule

`default_nettype wire

/* src/nrx_hv_timing.sv */
`default_nettype none

`include "nrx_params.svh"

module nrx_hv_timing (
	input  wire  CLK,
	input  wire  RESET,
	output logic pix_en,
	output nrx_video_pkg::hpos_t hpos,
	output nrx_video_pkg::vpos_t vpos,
	output logic hblank,
	output logic vblank,
	output logic hsync,
	output logic vsync,
	output logic vblank_strobe
);

	localparam int pdiv_w = $clog2(`NRX_PIX_DIV);

	logic [pdiv_w-1:0] pdiv;   // CLK phase within a pixel
	logic h_wrap;              // Last pixel of the line
	logic v_wrap;              // Last line of the frame

	// ------------------------------
	// Pixel enable
	// ------------------------------
	assign pix_en = (pdiv == pdiv_w'(`NRX_PIX_DIV - 1));

	always_ff @(posedge CLK) begin
		if (RESET) begin
			pdiv <= '0;
		end else if (pix_en) begin
			pdiv <= '0;
		end else begin
			pdiv <= pdiv + 1'b1;
		end
	end

	// ------------------------------
	// Raster counters
	// ------------------------------
	assign h_wrap = (hpos == nrx_video_pkg::hpos_t'(`NRX_H_TOTAL - 1));
	assign v_wrap = (vpos == nrx_video_pkg::vpos_t'(`NRX_V_TOTAL - 1));

	always_ff @(posedge CLK) begin
		if (RESET) begin
			hpos <= '0;
			vpos <= '0;
		end else if (pix_en) begin
			if (h_wrap) begin
				hpos <= '0;
				// Line done, step the line count
				vpos <= v_wrap ? '0 : vpos + 1'b1;
			end else begin
				hpos <= hpos + 1'b1;
			end
		end
	end

	// ------------------------------
	// Blanking, sync, vblank request
	// ------------------------------
	// Decoded straight from the counters, no extra latency
	assign hblank = (hpos >= `NRX_H_VISIBLE);
	assign vblank = (vpos >= `NRX_V_VISIBLE);

	assign hsync = (hpos >= `NRX_HSYNC_START) &&
	               (hpos <  `NRX_HSYNC_START + `NRX_SYNC_LEN);   // Active high
	assign vsync = (vpos >= `NRX_VSYNC_START) &&
	               (vpos <  `NRX_VSYNC_START + `NRX_SYNC_LEN);

	// Wide enough to span at least one CPU enable
	assign vblank_strobe = (vpos == `NRX_VBLK_LINE) && (hpos <= `NRX_VBLK_HMAX);

endmodule

`default_nettype wire

/* src/nrx_cpu_glue.sv */
`default_nettype none

`include "nrx_params.svh"

module nrx_cpu_glue (
	input  wire  CLK,
	input  wire  RESET,
	input  wire  nrx_bus_pkg::addr_t addr,
	input  wire  nrx_bus_pkg::byte_t wdata,
	input  wire  mreq_n,
	input  wire  iorq_n,
	input  wire  rd_n,
	input  wire  wr_n,
	input  wire  m1_n,
	input  wire  rfsh_n,
	input  wire  nrx_bus_pkg::byte_t ctr1,   // Controls, active low
	input  wire  nrx_bus_pkg::byte_t ctr2,
	input  wire  nrx_bus_pkg::byte_t dsw1,
	input  wire  nrx_bus_pkg::byte_t dsw2,
	input  wire  mod_jungler,
	output logic [14:0] rom_addr,
	input  wire  nrx_bus_pkg::byte_t rom_data,
	output nrx_bus_pkg::byte_t rdata,
	output logic cpu_cen,
	output logic [1:0] lamp,
	output logic bang,
	output nrx_bus_pkg::byte_t snd_cmd,
	output logic ie_wr,
	output logic ie_bit,
	output logic vec_wr,
	output nrx_bus_pkg::byte_t vec_data,
	input  wire  nrx_bus_pkg::byte_t vec_rdata
);

	localparam int cdiv_w   = $clog2(`NRX_CPU_DIV);
	localparam int cen_phase = 3;   // First enable on 4th CLK out of reset

	logic [cdiv_w-1:0] cdiv;
	logic mem_cyc, mem_rd, mem_wr;
	logic rom_rd, ram_sel, inp_rd, snd_wr, lat_wr;
	nrx_bus_pkg::latch_t lat_idx;
	nrx_bus_pkg::byte_t ram_q, inp_q;

	// ------------------------------
	// CPU clock enable
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (RESET) begin
			cdiv <= '0;
		end else if (cdiv == cdiv_w'(`NRX_CPU_DIV - 1)) begin
			cdiv <= '0;
		end else begin
			cdiv <= cdiv + 1'b1;
		end
	end

	assign cpu_cen = (cdiv == cdiv_w'(cen_phase));

	// ------------------------------
	// Address decode
	// ------------------------------
	assign mem_cyc = ~mreq_n & rfsh_n;       // Refresh cycles ignored
	assign mem_rd  = mem_cyc & ~rd_n;
	assign mem_wr  = mem_cyc & ~wr_n;

	assign rom_rd  = mem_rd & ~addr[15];                  // 0000-7FFF
	assign ram_sel = (addr[15:11] == 5'b10011);           // 9800-9FFF
	assign inp_rd  = mem_rd & (addr[15:12] == 4'hA);      // A000-AFFF
	assign snd_wr  = mem_wr & (addr[15:5] == 11'h508);    // A100-A11F
	assign lat_wr  = mem_wr & (addr[15:3] == 13'h1430);   // A180-A187
	assign lat_idx = nrx_bus_pkg::latch_t'(addr[2:0]);

	assign rom_addr = addr[14:0];   // External program ROM

	// Work RAM
	nrx_spram #(
		.ram_aw(`NRX_RAM_AW)
	) work_ram (
		.CLK (CLK),
		.addr(addr[`NRX_RAM_AW-1:0]),
		.we  (mem_wr & ram_sel & cpu_cen),   // One write per bus cycle
		.d   (wdata),
		.q   (ram_q)
	);

	// Controller / DIP switch mux
	always_comb begin
		case (addr[8:7])
			2'b00:   inp_q = ctr1;
			2'b01:   inp_q = ctr2;
			2'b10:   inp_q = dsw1;
			default: inp_q = mod_jungler ? dsw2 : dsw1;   // Jungler has a second bank
		endcase
	end

	// ------------------------------
	// Latches
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (RESET) begin
			bang    <= 1'b0;
			lamp    <= 2'b00;
			snd_cmd <= '0;
		end else if (cpu_cen) begin
			if (snd_wr)
				snd_cmd <= wdata;   // Command to the sound board
			if (lat_wr) begin
				case (lat_idx)
					nrx_bus_pkg::bang:  bang    <= wdata[0];
					nrx_bus_pkg::lamp0: lamp[0] <= wdata[0];
					nrx_bus_pkg::lamp1: lamp[1] <= wdata[0];
					default: ;   // Enable is kept by the interrupt block
				endcase
			end
		end
	end

	// Strobes to the interrupt controller
	assign ie_wr    = cpu_cen & lat_wr & (lat_idx == nrx_bus_pkg::irq_enable);
	assign ie_bit   = wdata[0];
	assign vec_wr   = cpu_cen & ~iorq_n & ~wr_n & m1_n;   // OUT to any port
	assign vec_data = wdata;

	// Read data bus, all sources gated then ORed
	assign rdata = (rom_rd ? rom_data : '0)
	             | ((mem_rd & ram_sel) ? ram_q : '0)
	             | (inp_rd ? inp_q : '0)
	             | vec_rdata;   // Zero outside an acknowledge

endmodule

`default_nettype wire

/* src/nrx_irq_ctrl.sv */
`default_nettype none

module nrx_irq_ctrl (
	input  wire  CLK,
	input  wire  RESET,
	input  wire  cpu_cen,
	input  wire  vblank_strobe,
	input  wire  ie_wr,
	input  wire  ie_bit,
	input  wire  vec_wr,
	input  wire  nrx_bus_pkg::byte_t vec_data,
	input  wire  m1_n,
	input  wire  iorq_n,
	input  wire  mod_jungler,
	output nrx_bus_pkg::byte_t vec_rdata,
	output logic int_n,
	output logic nmi_n
);

	logic ie;                    // Enable latch at A181
	logic pending;               // Vblank seen since last enable write
	nrx_bus_pkg::byte_t vec;     // Mode 2 vector
	logic irq;

	// ------------------------------
	// Registers
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (RESET) begin
			ie      <= 1'b0;
			pending <= 1'b0;
			vec     <= '0;
		end else begin
			if (cpu_cen && vblank_strobe)
				pending <= 1'b1;
			if (ie_wr) begin
				ie      <= ie_bit;
				pending <= 1'b0;   // Acts as the acknowledge too
			end
			if (vec_wr)
				vec <= vec_data;
		end
	end

	// ------------------------------
	// Outputs
	// ------------------------------
	// Vector on the bus only while M1 and IORQ are both low
	assign vec_rdata = (~m1_n & ~iorq_n) ? vec : '0;

	assign irq = pending & ie;

	// Jungler takes the request as NMI
	assign int_n = ~(irq & ~mod_jungler);
	assign nmi_n = ~(irq &  mod_jungler);

endmodule

`default_nettype wire

/* src/nrx_main.sv */
`default_nettype none

module nrx_main (
	input  wire  CLK,
	input  wire  RESET,
	// CPU bus from the external Z80
	input  wire  nrx_bus_pkg::addr_t addr,
	input  wire  nrx_bus_pkg::byte_t wdata,
	input  wire  mreq_n,
	input  wire  iorq_n,
	input  wire  rd_n,
	input  wire  wr_n,
	input  wire  m1_n,
	input  wire  rfsh_n,
	output nrx_bus_pkg::byte_t rdata,
	output logic cpu_cen,
	output logic int_n,
	output logic nmi_n,
	// Program ROM
	output logic [14:0] rom_addr,
	input  wire  nrx_bus_pkg::byte_t rom_data,
	// Player inputs and DIP switches
	input  wire  nrx_bus_pkg::byte_t ctr1,
	input  wire  nrx_bus_pkg::byte_t ctr2,
	input  wire  nrx_bus_pkg::byte_t dsw1,
	input  wire  nrx_bus_pkg::byte_t dsw2,
	input  wire  mod_jungler,
	// Board outputs
	output logic [1:0] lamp,
	output logic bang,
	output nrx_bus_pkg::byte_t snd_cmd,
	// Video timing
	output logic pix_en,
	output nrx_video_pkg::hpos_t hpos,
	output nrx_video_pkg::vpos_t vpos,
	output logic hblank,
	output logic vblank,
	output logic hsync,
	output logic vsync
);

	// ------------------------------
	// Internal links
	// ------------------------------
	logic vblank_strobe;
	logic ie_wr, ie_bit, vec_wr;
	nrx_bus_pkg::byte_t vec_data, vec_rdata;

	nrx_hv_timing hv_timing_inst (
		.CLK          (CLK),
		.RESET        (RESET),
		.pix_en       (pix_en),
		.hpos         (hpos),
		.vpos         (vpos),
		.hblank       (hblank),
		.vblank       (vblank),
		.hsync        (hsync),
		.vsync        (vsync),
		.vblank_strobe(vblank_strobe)
	);

	nrx_cpu_glue cpu_glue_inst (
		.CLK        (CLK),
		.RESET      (RESET),
		.addr       (addr),
		.wdata      (wdata),
		.mreq_n     (mreq_n),
		.iorq_n     (iorq_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.m1_n       (m1_n),
		.rfsh_n     (rfsh_n),
		.ctr1       (ctr1),
		.ctr2       (ctr2),
		.dsw1       (dsw1),
		.dsw2       (dsw2),
		.mod_jungler(mod_jungler),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.rdata      (rdata),
		.cpu_cen    (cpu_cen),
		.lamp       (lamp),
		.bang       (bang),
		.snd_cmd    (snd_cmd),
		.ie_wr      (ie_wr),
		.ie_bit     (ie_bit),
		.vec_wr     (vec_wr),
		.vec_data   (vec_data),
		.vec_rdata  (vec_rdata)
	);

	nrx_irq_ctrl irq_ctrl_inst (
		.CLK          (CLK),
		.RESET        (RESET),
		.cpu_cen      (cpu_cen),
		.vblank_strobe(vblank_strobe),
		.ie_wr        (ie_wr),
		.ie_bit       (ie_bit),
		.vec_wr       (vec_wr),
		.vec_data     (vec_data),
		.m1_n         (m1_n),
		.iorq_n       (iorq_n),
		.mod_jungler  (mod_jungler),
		.vec_rdata    (vec_rdata),
		.int_n        (int_n),
		.nmi_n        (nmi_n)
	);

endmodule

`default_nettype wire

/* verif/nrx_clk_gen.sv */
`default_nettype none

module nrx_clk_gen #(
	parameter int period_ns    = 20,   // CLK period
	parameter int reset_cycles = 10    // RESET length in CLK cycles
) (
	output logic CLK,
	output logic RESET
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLK = 1'b0;
		forever #(period_ns / 2) CLK = ~CLK;
	end

	// Held over the first rising edges, released on a falling edge
	initial begin
		RESET = 1'b1;
		repeat (reset_cycles) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b0;
	end

endmodule

`default_nettype wire

/* verif/nrx_main_tb.sv */
`default_nettype none

`include "nrx_params.svh"

module nrx_main_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int line_clk  = `NRX_H_TOTAL * `NRX_PIX_DIV;   // 1536 CLK
	localparam int frame_clk = line_clk * `NRX_V_TOTAL;       // 405504 CLK
	// Three frames plus 2000 CPU cycles
	localparam longint watchdog_ns = (3 * frame_clk + 2000 * `NRX_CPU_DIV) * 20;

	logic CLK, RESET;
	nrx_bus_pkg::addr_t addr;
	nrx_bus_pkg::byte_t wdata, rdata, rom_data, snd_cmd;
	nrx_bus_pkg::byte_t ctr1, ctr2, dsw1, dsw2;
	logic mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n;
	logic cpu_cen, int_n, nmi_n, mod_jungler, bang;
	logic [14:0] rom_addr;
	logic [1:0] lamp;
	logic pix_en, hblank, vblank, hsync, vsync;
	nrx_video_pkg::hpos_t hpos;
	nrx_video_pkg::vpos_t vpos;

	int errors = 0;
	int raster_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic [31:0] lcg_state = 32'd56285;
	nrx_bus_pkg::byte_t last_rdata;   // Bus value just before the enable edge
	logic [14:0] last_rom_addr;
	nrx_bus_pkg::byte_t ram_model [int];
	int hs_cnt, vs_cnt, hs_periods, vs_periods, hb_rises, vb_rises;
	logic hs_seen, vs_seen, hsync_q, vsync_q, hblank_q, vblank_q;
	int cen_cnt, pe_cnt;
	logic cen_seen, pe_seen;

	nrx_clk_gen #(.period_ns(20), .reset_cycles(10)) clk_gen_inst (.CLK(CLK), .RESET(RESET));

	nrx_main nrx_main_inst (
		.CLK(CLK), .RESET(RESET),
		.addr(addr), .wdata(wdata), .mreq_n(mreq_n), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n), .rfsh_n(rfsh_n),
		.rdata(rdata), .cpu_cen(cpu_cen), .int_n(int_n), .nmi_n(nmi_n),
		.rom_addr(rom_addr), .rom_data(rom_data),
		.ctr1(ctr1), .ctr2(ctr2), .dsw1(dsw1), .dsw2(dsw2), .mod_jungler(mod_jungler),
		.lamp(lamp), .bang(bang), .snd_cmd(snd_cmd),
		.pix_en(pix_en), .hpos(hpos), .vpos(vpos),
		.hblank(hblank), .vblank(vblank), .hsync(hsync), .vsync(vsync)
	);

	// Program ROM model whose bytes depend on all 15 address bits
	function automatic nrx_bus_pkg::byte_t rom_fill(input logic [14:0] a);
		return a[7:0] ^ {a[14:8], 1'b1} ^ 8'hA5;
	endfunction

	assign rom_data = rom_fill(rom_addr);

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
	                           input logic [15:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d error(s)", name, errors - err0);
		end
	endtask

	// ------------------------------
	// CPU bus cycles
	// ------------------------------
	// Returns on the falling edge just before an enable edge
	task automatic wait_cen();
		@(negedge CLK);
		while (!cpu_cen)
			@(negedge CLK);
	endtask

	// Flags are active high here
	// One bus state lasts a full CPU cycle
	task automatic bus_cycle(input nrx_bus_pkg::addr_t a, input nrx_bus_pkg::byte_t d,
	                         input logic mreq, input logic iorq, input logic rd,
	                         input logic wr, input logic m1);
		wait_cen();
		@(negedge CLK);
		addr   = a;
		wdata  = d;
		mreq_n = ~mreq;
		iorq_n = ~iorq;
		rd_n   = ~rd;
		wr_n   = ~wr;
		m1_n   = ~m1;
		wait_cen();
		last_rdata    = rdata;
		last_rom_addr = rom_addr;
		@(negedge CLK);   // Latches written and bus back to idle
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
	endtask

	task automatic mem_read(input nrx_bus_pkg::addr_t a);
		bus_cycle(a, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic mem_write(input nrx_bus_pkg::addr_t a, input nrx_bus_pkg::byte_t d);
		bus_cycle(a, d, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	// Stay out of the vblank window so a cleared request stays cleared
	task automatic set_irq_enable(input logic en);
		while (vpos == `NRX_VBLK_LINE && hpos <= `NRX_VBLK_HMAX)
			@(negedge CLK);
		mem_write(16'hA180 + 16'(nrx_bus_pkg::irq_enable), {7'b0, en});
	endtask

	task automatic wait_irq(input logic on_nmi);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < frame_clk + line_clk) begin
			@(negedge CLK);
			seen = on_nmi ? !nmi_n : !int_n;
			n++;
		end
		assert (seen) else begin
			$display("Interrupt line %s did not go low within a frame",
			         on_nmi ? "nmi_n" : "int_n");
			errors++;
		end
		check_value("vpos", vpos, `NRX_VBLK_LINE);
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic ram_rom_access();
		int i, err0;
		logic [31:0] w;
		nrx_bus_pkg::addr_t a;
		err0 = errors;
		for (i = 0; i < 24; i++) begin
			w = rand_word();
			a = 16'h9800 + 16'(w[26:16]);
			mem_write(a, w[7:0]);
			ram_model[int'(a)] = w[7:0];
		end
		foreach (ram_model[k]) begin
			mem_read(16'(k));
			check_value("rdata", last_rdata, ram_model[k]);
		end
		for (i = 0; i < 16; i++) begin   // Program ROM reads
			w = rand_word();
			mem_read({1'b0, w[30:16]});
			check_value("rom_addr", last_rom_addr, w[30:16]);
			check_value("rdata", last_rdata, rom_fill(w[30:16]));
		end
		finish_test("work RAM and ROM", err0);
	endtask

	task automatic input_mux_reads();
		int mode, sel, err0;
		logic [31:0] w;
		nrx_bus_pkg::byte_t exp;
		err0 = errors;
		for (mode = 0; mode < 2; mode++) begin
			w = rand_word();
			@(negedge CLK);
			mod_jungler = mode[0];
			ctr1 = w[7:0];
			ctr2 = w[15:8];
			dsw1 = w[23:16];
			dsw2 = w[31:24];
			for (sel = 0; sel < 8; sel++) begin
				w = rand_word();
				mem_read({4'hA, w[11:9], sel[1:0], w[6:0]});
				case (sel[1:0])
					2'd0:    exp = ctr1;
					2'd1:    exp = ctr2;
					2'd2:    exp = dsw1;
					default: exp = mode[0] ? dsw2 : dsw1;   // Second bank on Jungler
				endcase
				check_value("rdata", last_rdata, exp);
			end
		end
		@(negedge CLK);
		mod_jungler = 1'b0;
		finish_test("inputs", err0);
	endtask

	task automatic latch_writes();
		int i, err0;
		logic [31:0] w;
		logic [1:0] exp_lamp;
		logic exp_bang;
		nrx_bus_pkg::byte_t exp_snd;
		err0 = errors;
		exp_lamp = 2'b00;
		exp_bang = 1'b0;
		exp_snd  = 8'h00;
		for (i = 0; i <= 20; i++) begin
			check_value("lamp", lamp, exp_lamp);   // First pass sees reset values
			check_value("bang", bang, exp_bang);
			check_value("snd_cmd", snd_cmd, exp_snd);
			w = rand_word();
			case (w[1:0])
				2'd0: begin
					mem_write(16'hA180 + 16'(nrx_bus_pkg::bang), w[15:8]);
					exp_bang = w[8];
				end
				2'd1: begin
					mem_write(16'hA180 + 16'(nrx_bus_pkg::lamp0), w[15:8]);
					exp_lamp[0] = w[8];
				end
				2'd2: begin
					mem_write(16'hA180 + 16'(nrx_bus_pkg::lamp1), w[15:8]);
					exp_lamp[1] = w[8];
				end
				default: begin
					mem_write(16'hA100 + 16'(w[20:16]), w[15:8]);
					exp_snd = w[15:8];
				end
			endcase
		end
		check_value("lamp", lamp, exp_lamp);   // Last write
		check_value("bang", bang, exp_bang);
		check_value("snd_cmd", snd_cmd, exp_snd);
		finish_test("latches", err0);
	endtask

	task automatic vector_cycles();
		int i, err0;
		logic [31:0] w;
		err0 = errors;
		for (i = 0; i < 4; i++) begin
			w = rand_word();
			bus_cycle({8'h00, w[15:8]}, w[7:0], 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);   // OUT
			bus_cycle(16'h0000, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);            // Ack
			check_value("rdata", last_rdata, w[7:0]);
			mem_read(16'hC000 + 16'(w[29:16]));   // Nothing mapped here
			check_value("rdata", last_rdata, 8'h00);
			bus_cycle({8'h00, w[15:8]}, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);   // IN
			check_value("rdata", last_rdata, 8'h00);
		end
		finish_test("vector", err0);
	endtask

	task automatic vblank_interrupt();
		int n, err0;
		err0 = errors;
		set_irq_enable(1'b1);
		wait_irq(1'b0);
		set_irq_enable(1'b1);   // Clears the request and keeps the enable on
		check_value("int_n", int_n, 1'b1);
		@(negedge CLK);
		mod_jungler = 1'b1;
		wait_irq(1'b1);
		set_irq_enable(1'b1);
		check_value("nmi_n", nmi_n, 1'b1);
		set_irq_enable(1'b0);
		n = 0;
		while (n < frame_clk && int_n && nmi_n) begin   // Whole frame including vblank
			@(negedge CLK);
			n++;
		end
		assert (n == frame_clk) else begin
			$display("Interrupt line went low with the enable cleared");
			errors++;
		end
		mod_jungler = 1'b0;
		finish_test("interrupt", err0);
	endtask

	// ------------------------------
	// Raster checks
	// ------------------------------
	always @(posedge CLK) begin
		if (RESET) begin
			hs_cnt = 0;
			vs_cnt = 0;
			hs_periods = 0;
			vs_periods = 0;
			hb_rises = 0;
			vb_rises = 0;
			hs_seen = 1'b0;
			vs_seen = 1'b0;
			hsync_q = 1'b0;
			vsync_q = 1'b0;
			hblank_q = 1'b0;
			vblank_q = 1'b0;
			cen_cnt = 0;
			pe_cnt = 0;
			cen_seen = 1'b0;
			pe_seen = 1'b0;
		end else begin
			hs_cnt++;
			vs_cnt++;
			cen_cnt++;
			pe_cnt++;
			// First enable on the fourth rising edge out of reset
			if (cpu_cen) begin
				assert (cen_cnt == (cen_seen ? `NRX_CPU_DIV : 4)) else begin
					$display("FAILED cpu_cen period: got %h, expected %h", cen_cnt,
					         cen_seen ? `NRX_CPU_DIV : 4);
					raster_errors++;
				end
				cen_seen = 1'b1;
				cen_cnt = 0;
			end
			if (pix_en) begin
				if (pe_seen) begin
					assert (pe_cnt == `NRX_PIX_DIV) else begin
						$display("FAILED pix_en period: got %h, expected %h", pe_cnt,
						         `NRX_PIX_DIV);
						raster_errors++;
					end
				end
				pe_seen = 1'b1;
				pe_cnt = 0;
			end
			if (hsync && !hsync_q) begin
				if (hs_seen) begin
					assert (hs_cnt == line_clk) else begin
						$display("FAILED hsync period: got %h, expected %h", hs_cnt, line_clk);
						raster_errors++;
					end
					hs_periods++;
				end
				hs_seen = 1'b1;
				hs_cnt = 0;
			end
			if (vsync && !vsync_q) begin
				if (vs_seen) begin
					assert (vs_cnt == frame_clk) else begin
						$display("FAILED vsync period: got %h, expected %h", vs_cnt, frame_clk);
						raster_errors++;
					end
					vs_periods++;
				end
				vs_seen = 1'b1;
				vs_cnt = 0;
			end
			hb_rises += int'(hblank && !hblank_q);
			vb_rises += int'(vblank && !vblank_q);
			hsync_q  = hsync;
			vsync_q  = vsync;
			hblank_q = hblank;
			vblank_q = vblank;
		end
	end

	// Blanking starts on the first pixel and line past the picture
	assert property (@(posedge CLK) disable iff (RESET) $rose(hblank) |-> hpos == 9'd288)
	else begin
		$display("FAILED hpos at hblank start: got %h, expected %h", $sampled(hpos), 9'd288);
		raster_errors++;
	end

	assert property (@(posedge CLK) disable iff (RESET) $rose(vblank) |-> vpos == 9'd224)
	else begin
		$display("FAILED vpos at vblank start: got %h, expected %h", $sampled(vpos), 9'd224);
		raster_errors++;
	end

	// Request only on the line of the current mode and only at line 224
	assert property (@(posedge CLK) disable iff (RESET) mod_jungler ? int_n : nmi_n)
	else begin
		$display("Interrupt request appeared on the line of the other mode");
		errors++;
	end

	assert property (@(posedge CLK) disable iff (RESET)
		($fell(int_n) || $fell(nmi_n)) |-> vpos == 9'd224)
	else begin
		$display("FAILED vpos at interrupt: got %h, expected %h", $sampled(vpos), 9'd224);
		errors++;
	end

	// ------------------------------
	// Main sequence and watchdog
	// ------------------------------
	initial begin
		int err0;
		addr = '0;
		wdata = '0;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		rfsh_n = 1'b1;
		ctr1 = 8'hFF;   // Controls idle high
		ctr2 = 8'hFF;
		dsw1 = 8'h00;
		dsw2 = 8'h00;
		mod_jungler = 1'b0;
		@(negedge CLK);
		while (RESET)
			@(negedge CLK);
		latch_writes();   // Reset values first
		ram_rom_access();
		input_mux_reads();
		vector_cycles();
		vblank_interrupt();
		err0 = errors;
		errors += raster_errors;
		assert (hs_periods > 0 && vs_periods > 0 && hb_rises > 0 && vb_rises > 0) else begin
			$display("Raster did not run through a full frame period");
			errors++;
		end
		finish_test("raster", err0);
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the tests did not complete", watchdog_ns);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/nrx_bus_pkg.sv
src/nrx_video_pkg.sv
src/nrx_spram.sv
src/nrx_hv_timing.sv
src/nrx_cpu_glue.sv
src/nrx_irq_ctrl.sv
src/nrx_main.sv
verif/nrx_clk_gen.sv
verif/nrx_main_tb.sv

/* Bender.yml */
package:
  name: nrx_main

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/nrx_bus_pkg.sv
      - src/nrx_video_pkg.sv
      - src/nrx_spram.sv
      - src/nrx_hv_timing.sv
      - src/nrx_cpu_glue.sv
      - src/nrx_irq_ctrl.sv
      - src/nrx_main.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/nrx_clk_gen.sv
      - verif/nrx_main_tb.sv
